// File: hdl/alu.sv
`timescale 1ns/100ps

module alu import rvPkg::*; (
    input  wordT   a,
    input  wordT   b,
    input  aluSelT sel,
    output wordT   result,
    output logic   zero
);

    logic lessThan;

    // Signed compare for SLT
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (sel)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {31'b0, lessThan};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);   // Used by BEQ

endmodule

// File: hdl/ctrlIf.sv
`timescale 1ns/100ps

interface ctrlIf import rvPkg::*; ();

    logic   regWrite;
    logic   aluSrc;   // 1 selects imm as ALU operand b
    logic   memWrite;
    logic   memToReg; // 1 writes back the load data
    logic   branch;
    aluSelT aluSel;
    wordT   imm;

    modport driver (
        output regWrite, aluSrc, memWrite, memToReg, branch, aluSel, imm
    );

    modport user (
        input regWrite, aluSrc, memWrite, memToReg, branch, aluSel, imm
    );

endinterface

// File: hdl/dataMem.sv
`timescale 1ns/100ps

module dataMem import rvPkg::*; (
    input  logic CLK,
    input  logic we,
    input  wordT addr,
    input  wordT wData,
    output wordT rData
);

    wordT mem [dataMemDepth];

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < dataMemDepth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[addr[dataMemAw+1:2]] <= wData;   // Word store only
        end
    end

    assign rData = mem[addr[dataMemAw+1:2]];

endmodule

// File: hdl/instDecode.sv
`timescale 1ns/100ps

module instDecode import rvPkg::*; (
    input wordT   inst,
    ctrlIf.driver ctrl
);

    opcodeT opcode;
    funct3T funct3;
    logic   isSub;
    aluSelT arithSel;
    wordT   immI;
    wordT   immS;
    wordT   immB;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // Bit 30 only picks SUB for the register form, ADDI ignores it
    assign isSub = (opcode == opRType) && (inst[30] == f7SubBit);

    // Sign-extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // ALU control for the arithmetic forms
    always_comb begin
        case (funct3)
            f3AddSub: arithSel = isSub ? aluSub : aluAdd;
            f3And:    arithSel = aluAnd;
            f3Or:     arithSel = aluOr;
            f3Xor:    arithSel = aluXor;
            f3Slt:    arithSel = aluSlt;
            default:  arithSel = aluAdd;   // Outside the subset
        endcase
    end

    // Main control
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluSel   = aluAdd;
        ctrl.imm      = '0;

        case (opcode)
            opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = arithSel;
            end
            opIArith: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluSel   = arithSel;
                ctrl.imm      = immI;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.imm      = immI;   // Address is rs1 + offset
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immS;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluSel = aluSub;   // Equality via zero flag
                ctrl.imm    = immB;
            end
            default: begin
                // Unknown opcode behaves as a no-op
            end
        endcase
    end

endmodule

// File: hdl/instMem.sv
`timescale 1ns/100ps

module instMem import rvPkg::*; (
    input  logic                 CLK,
    input  logic                 progWe,
    input  logic [instMemAw-1:0] progAddr,
    input  wordT                 progData,
    input  wordT                 addr,
    output wordT                 inst
);

    wordT mem [instMemDepth];

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Fetch by word index, upper address bits wrap
    assign inst = mem[addr[instMemAw+1:2]];

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/100ps

module pcUnit import rvPkg::*; (
    input  logic CLK,
    input  logic rstN,
    input  logic run,
    input  logic takeBranch,
    input  wordT imm,
    output wordT pc
);

    wordT pcPlus4;
    wordT branchTarget;
    wordT nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm;   // B immediate already carries bit 0
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (run) begin   // Holds while paused
            pc <= nextPc;
        end
    end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/100ps

module regFile import rvPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    we,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT rd,
    input  wordT    wData,
    output wordT    rData1,
    output wordT    rData2
);

    wordT regs [regCount];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin   // x0 is never written
            regs[rd] <= wData;
        end
    end

    // Asynchronous read ports
    assign rData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/rvPkg.sv
package rvPkg;

    // Memory sizes in words
    localparam int instMemDepth = 64;
    localparam int dataMemDepth = 64;
    localparam int instMemAw    = $clog2(instMemDepth); // 6 bits
    localparam int dataMemAw    = $clog2(dataMemDepth); // 6 bits
    localparam int regCount     = 32;

    typedef logic [31:0] wordT;     // Data, address or instruction
    typedef logic [4:0]  regAddrT;
    typedef logic [3:0]  aluSelT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;

    // Major opcodes of the supported subset
    localparam opcodeT opRType  = 7'b0110011;
    localparam opcodeT opIArith = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;

    // funct3 codes
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // inst[30] value that turns ADD into SUB
    localparam logic f7SubBit = 1'b1;

    // ALU operation selects
    localparam aluSelT aluAdd = 4'd0;
    localparam aluSelT aluSub = 4'd1;
    localparam aluSelT aluAnd = 4'd2;
    localparam aluSelT aluOr  = 4'd3;
    localparam aluSelT aluXor = 4'd4;
    localparam aluSelT aluSlt = 4'd5;

endpackage

// File: hdl/singleCpu.sv
`timescale 1ns/100ps

module singleCpu import rvPkg::*; (
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 run,
    input  logic                 progWe,
    input  logic [instMemAw-1:0] progAddr,
    input  wordT                 progData,
    output wordT                 pc,
    output wordT                 inst,
    output logic                 regWeOut,
    output regAddrT              regWAddrOut,
    output wordT                 regWDataOut,
    output logic                 memWeOut,
    output wordT                 memAddrOut,
    output wordT                 memWDataOut
);

    ctrlIf ctrlBus ();

    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    rData1;
    wordT    rData2;
    wordT    aluB;
    wordT    aluResult;
    wordT    memRData;
    wordT    wbData;
    logic    aluZero;
    logic    takeBranch;
    logic    writeEn;

    // Register fields straight from the instruction word
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    assign aluB   = ctrlBus.aluSrc ? ctrlBus.imm : rData2;
    assign wbData = ctrlBus.memToReg ? memRData : aluResult;

    // BEQ compares with SUB, so zero means equal
    assign takeBranch = ctrlBus.branch & aluZero;

    // No state changes unless running and out of reset
    assign writeEn  = run & rstN;
    assign regWeOut = ctrlBus.regWrite & writeEn;
    assign memWeOut = ctrlBus.memWrite & writeEn;

    assign regWAddrOut = rd;
    assign regWDataOut = wbData;
    assign memAddrOut  = aluResult;
    assign memWDataOut = rData2;

    pcUnit pcUnit_inst (
        .CLK        (CLK),
        .rstN       (rstN),
        .run        (run),
        .takeBranch (takeBranch),
        .imm        (ctrlBus.imm),
        .pc         (pc)
    );

    instMem instMem_inst (
        .CLK      (CLK),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .addr     (pc),
        .inst     (inst)
    );

    regFile regFile_inst (
        .CLK    (CLK),
        .rstN   (rstN),
        .we     (regWeOut),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wData  (wbData),
        .rData1 (rData1),
        .rData2 (rData2)
    );

    instDecode instDecode_inst (
        .inst (inst),
        .ctrl (ctrlBus.driver)
    );

    alu alu_inst (
        .a      (rData1),
        .b      (aluB),
        .sel    (ctrlBus.aluSel),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMem dataMem_inst (
        .CLK   (CLK),
        .we    (memWeOut),
        .addr  (aluResult),
        .wData (rData2),
        .rData (memRData)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the single-cycle CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbSingleCpu -o simSingleCpu

status=0
./obj_dir/simSingleCpu > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: tb.f
hdl/rvPkg.sv
hdl/ctrlIf.sv
hdl/pcUnit.sv
hdl/instMem.sv
hdl/regFile.sv
hdl/instDecode.sv
hdl/alu.sv
hdl/dataMem.sv
hdl/singleCpu.sv
verification/singleCpu_props.sv
verification/tbSingleCpu.sv

// File: verification/singleCpu_props.sv
`timescale 1ns/100ps

module singleCpuProps import rvPkg::*; (
    input logic CLK,
    input logic rstN,
    input logic run,
    input wordT pc,
    input logic regWeOut,
    input logic memWeOut
);

    // No state change while stopped or in reset
    idleNoWrites: assert property (@(posedge CLK) (!rstN || !run) |-> (!regWeOut && !memWeOut))
        else $error("write strobe active while run or rstN is low");

    resetClearsPc: assert property (@(posedge CLK) $rose(rstN) |-> (pc == '0))
        else $error("pc not zero in the cycle after reset");

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) (pc[1:0] == 2'b00))
        else $error("pc lost word alignment");   // Branch offsets are word multiples

endmodule

bind singleCpu singleCpuProps singleCpuProps_inst (
    .CLK      (CLK),
    .rstN     (rstN),
    .run      (run),
    .pc       (pc),
    .regWeOut (regWeOut),
    .memWeOut (memWeOut)
);

// File: verification/tbSingleCpu.sv
`timescale 1ns/100ps

module tbSingleCpu import rvPkg::*; ();

    localparam int resetCycles = 5;
    localparam int runCycles   = 400;
    localparam int pauseStart  = 200;   // Run cycle where run drops
    localparam int pauseCycles = 8;
    localparam int cycleLimit  = 600;   // Reset, load, run and pause with margin

    logic                 CLK;
    logic                 rstN;
    logic                 run;
    logic                 progWe;
    logic [instMemAw-1:0] progAddr;
    wordT                 progData;
    wordT                 pc;
    wordT                 inst;
    logic                 regWeOut;
    regAddrT              regWAddrOut;
    wordT                 regWDataOut;
    logic                 memWeOut;
    wordT                 memAddrOut;
    wordT                 memWDataOut;

    // ISA model state
    wordT modelProg [instMemDepth];
    wordT modelRegs [regCount];
    wordT modelMem  [dataMemDepth];
    wordT modelPc;

    logic [31:0] lcgState = 32'he880;
    int          cycleCount = 0;
    int          pcErrors = 0;
    int          instErrors = 0;
    int          regErrors = 0;
    int          memErrors = 0;

    singleCpu singleCpu_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("Timeout: the run did not end within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [23:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:8];   // Low bits of an LCG repeat quickly
    endfunction

    // Random instruction for program slot idx
    function automatic wordT makeInst(input int idx);
        logic [23:0] r1;
        logic [23:0] r2;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [12:0] bOff;
        int          kind;
        int          delta;
        r1 = lcgNext();
        r2 = lcgNext();
        kind = int'(r1[3:0]);
        off = {4'b0, r2[5:0], 2'b00};   // Word aligned, below 256
        if (kind < 4) begin
            case (int'(r2[7:0]) % 5)
                0:       f3 = 3'b000;
                1:       f3 = 3'b111;
                2:       f3 = 3'b110;
                3:       f3 = 3'b100;
                default: f3 = 3'b010;
            endcase
            return {1'b0, r1[19] & (f3 == 3'b000), 5'b0, r1[18:14], r1[13:9], f3, r1[8:4],
                    opRType};
        end else if (kind < 8 || kind == 15) begin
            case (int'(r2[7:0]) % 3)
                0:       f3 = 3'b000;
                1:       f3 = 3'b111;
                default: f3 = 3'b110;
            endcase
            return {r2[23:12], r1[13:9], f3, r1[8:4], opIArith};
        end else if (kind < 10) begin
            return {off, 5'd0, 3'b010, r1[8:4], opLoad};
        end else if (kind < 12) begin
            return {off[11:5], r1[18:14], 5'd0, 3'b010, off[4:0], opStore};
        end else if (kind < 14) begin
            delta = int'(r2[1:0]) + 1;
            if (r2[2]) delta = -delta;
            if (idx + delta < 0 || idx + delta >= instMemDepth) delta = -delta;
            bOff = 13'(delta * 4);
            // Few source registers so that equal operands happen often
            return {bOff[12], bOff[10:5], 3'b0, r1[15:14], 3'b0, r1[10:9], 3'b000,
                    bOff[4:1], bOff[11], opBranch};
        end
        return {r2[23:0], r1[4], r1[23:20], 3'b111};   // Opcode outside the subset
    endfunction

    function automatic wordT arith(input logic [2:0] f3, input logic sub, input wordT x,
                                   input wordT y);
        case (f3)
            3'b000:  return sub ? x - y : x + y;
            3'b111:  return x & y;
            3'b110:  return x | y;
            3'b100:  return x ^ y;
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            default: return x + y;
        endcase
    endfunction

    task automatic checkPc(input wordT got, input wordT exp);
        if (got !== exp) begin
            pcErrors++;
            $display("[ERROR] %0t: pc is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic checkInst(input wordT got, input wordT exp);
        if (got !== exp) begin
            instErrors++;
            $display("[ERROR] %0t: inst is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic checkRegWrite(input logic gotWe, input regAddrT gotAddr, input wordT gotData,
                                 input logic expWe, input regAddrT expAddr, input wordT expData);
        if (gotWe !== expWe || (expWe && (gotAddr !== expAddr || gotData !== expData))) begin
            regErrors++;
            $display("[ERROR] %0t: register write we=%b x%0d=%h, expected we=%b x%0d=%h",
                     $time, gotWe, gotAddr, gotData, expWe, expAddr, expData);
        end
    endtask

    task automatic checkMemWrite(input logic gotWe, input wordT gotAddr, input wordT gotData,
                                 input logic expWe, input wordT expAddr, input wordT expData);
        if (gotWe !== expWe || (expWe && (gotAddr !== expAddr || gotData !== expData))) begin
            memErrors++;
            $display("[ERROR] %0t: memory write we=%b [%h]=%h, expected we=%b [%h]=%h",
                     $time, gotWe, gotAddr, gotData, expWe, expAddr, expData);
        end
    endtask

    // Predict the pending writes of the current instruction, compare, then commit
    task automatic stepModel(input logic running);
        wordT    mInst;
        wordT    a;
        wordT    b;
        wordT    immI;
        wordT    immS;
        wordT    immB;
        wordT    memAddr;
        wordT    loadAddr;
        wordT    expRegData;
        wordT    nextPc;
        logic    expRegWe;
        logic    expMemWe;
        regAddrT rd;
        mInst = modelProg[modelPc[7:2]];
        rd = mInst[11:7];
        a = modelRegs[mInst[19:15]];   // x0 entry stays zero
        b = modelRegs[mInst[24:20]];
        immI = {{20{mInst[31]}}, mInst[31:20]};
        immS = {{20{mInst[31]}}, mInst[31:25], mInst[11:7]};
        immB = {{20{mInst[31]}}, mInst[7], mInst[30:25], mInst[11:8], 1'b0};
        memAddr = a + immS;
        loadAddr = a + immI;
        expRegWe = 1'b0;
        expMemWe = 1'b0;
        expRegData = '0;
        nextPc = modelPc + 32'd4;
        case (mInst[6:0])
            opRType: begin
                expRegWe = 1'b1;
                expRegData = arith(mInst[14:12], mInst[30], a, b);
            end
            opIArith: begin
                expRegWe = 1'b1;
                expRegData = arith(mInst[14:12], 1'b0, a, immI);
            end
            opLoad: begin
                expRegWe = 1'b1;
                expRegData = modelMem[loadAddr[7:2]];
            end
            opStore:  expMemWe = 1'b1;
            opBranch: if (a == b) nextPc = modelPc + immB;
            default:  expRegWe = 1'b0;   // No-op
        endcase
        checkPc(pc, modelPc);
        checkRegWrite(regWeOut, regWAddrOut, regWDataOut, expRegWe & running, rd, expRegData);
        checkMemWrite(memWeOut, memAddrOut, memWDataOut, expMemWe & running, memAddr, b);
        if (running) begin
            if (expRegWe && rd != 5'd0) modelRegs[rd] = expRegData;
            if (expMemWe) modelMem[memAddr[7:2]] = b;
            modelPc = nextPc;
        end
    endtask

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        modelPc = '0;
        for (int i = 0; i < regCount; i++) modelRegs[i] = '0;
        for (int i = 0; i < dataMemDepth; i++) modelMem[i] = '0;
        for (int i = 0; i < instMemDepth; i++) modelProg[i] = makeInst(i);

        repeat (resetCycles) @(posedge CLK);
        rstN <= 1'b1;

        // Load with run low, pc must stay at 0 and no writes happen
        for (int i = 0; i < instMemDepth; i++) begin
            @(posedge CLK);
            progWe <= 1'b1;
            progAddr <= i[instMemAw-1:0];
            progData <= modelProg[i];
            @(negedge CLK);
            stepModel(1'b0);
        end
        @(posedge CLK);
        progWe <= 1'b0;
        run <= 1'b1;

        for (int c = 0; c < runCycles + pauseCycles; c++) begin
            @(negedge CLK);   // Outputs settled between edges
            checkInst(inst, modelProg[modelPc[7:2]]);
            stepModel(run);
            @(posedge CLK);
            if (c == pauseStart - 1) begin
                run <= 1'b0;
            end else if (c == pauseStart + pauseCycles - 1) begin
                run <= 1'b1;
            end
        end

        $display("Errors: pc %0d, inst %0d, register writes %0d, memory writes %0d",
                 pcErrors, instErrors, regErrors, memErrors);
        if (pcErrors + instErrors + regErrors + memErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
